// ==== mem_hierarchy_pkg.sv ====
package mem_hierarchy_pkg;

	// Word and address geometry
	localparam int WORD_W = 16;
	localparam int ADDR_W = 16;

	// Address splits into tag, index and offset
	localparam int LINE_WORDS = 4;
	localparam int OFFSET_W = 2;
	localparam int INDEX_W = 6;
	localparam int TAG_W = 8;
	localparam int LINE_ADDR_W = INDEX_W + TAG_W;
	localparam int NUM_LINES = 2 ** INDEX_W;

	// Unified memory access time in cycles
	localparam int MEM_LAT = 4;
	localparam int MEM_CNT_W = $clog2(MEM_LAT);
	localparam logic [MEM_CNT_W-1:0] MEM_CNT_LAST = MEM_CNT_W'(MEM_LAT - 1);

	// One cache line is moved whole or picked apart by word
	typedef union packed {
		logic [LINE_WORDS*WORD_W-1:0] raw;
		logic [LINE_WORDS-1:0][WORD_W-1:0] words;
	} line_t;

	typedef enum logic [1:0] {
		IDLE,
		I_FILL,
		D_WB,
		D_FILL
	} ctrl_state_t;

endpackage

// ==== cache.sv ====
`timescale 1ns/1ps

module cache (
	input logic clk,
	input logic i_reset,
	input logic [mem_hierarchy_pkg::LINE_ADDR_W-1:0] i_line_addr,
	input mem_hierarchy_pkg::line_t i_wr_line,
	input logic i_we,
	input logic i_set_dirty,
	output mem_hierarchy_pkg::line_t o_rd_line,
	output logic [mem_hierarchy_pkg::TAG_W-1:0] o_tag,
	output logic o_hit,
	output logic o_dirty
);

	mem_hierarchy_pkg::line_t line_mem [mem_hierarchy_pkg::NUM_LINES];
	logic [mem_hierarchy_pkg::TAG_W-1:0] tag_mem [mem_hierarchy_pkg::NUM_LINES];
	logic [mem_hierarchy_pkg::NUM_LINES-1:0] valid;
	logic [mem_hierarchy_pkg::NUM_LINES-1:0] dirty;

	logic [mem_hierarchy_pkg::INDEX_W-1:0] idx;
	logic [mem_hierarchy_pkg::TAG_W-1:0] line_tag;

	assign idx = i_line_addr[mem_hierarchy_pkg::INDEX_W-1:0];
	assign line_tag = i_line_addr[mem_hierarchy_pkg::LINE_ADDR_W-1:mem_hierarchy_pkg::INDEX_W];

	// Line and tag storage
	always_ff @(posedge clk) begin
		if (i_we) begin
			line_mem[idx].raw <= i_wr_line.raw;
			tag_mem[idx] <= line_tag;
		end
	end

	// Per-line state bits
	always_ff @(posedge clk) begin
		if (i_reset) begin
			valid <= '0;
			dirty <= '0;
		end else if (i_we) begin
			valid[idx] <= 1'b1;
			dirty[idx] <= i_set_dirty;
		end
	end

	// Lookup is combinational so hits answer in the same cycle
	always_comb begin
		o_rd_line.raw = line_mem[idx].raw;
		o_tag = tag_mem[idx];
		o_hit = valid[idx] && (tag_mem[idx] == line_tag);
		o_dirty = valid[idx] && dirty[idx];
	end

	// A store marks a line dirty only while that line is being written
	a_dirty_needs_we: assert property (
		@(posedge clk) disable iff (i_reset)
		i_set_dirty |-> i_we
	) else $error("cache: set_dirty without write enable");

endmodule

// ==== cache_controller.sv ====
`timescale 1ns/1ps

module cache_controller (
	input logic clk,
	input logic i_reset,
	input logic i_i_hit,
	input logic i_d_hit,
	input logic i_d_dirty,
	input logic i_d_re,
	input logic i_d_we,
	input logic i_u_rdy,
	output logic o_u_re,
	output logic o_u_we,
	output logic o_i_we,
	output logic o_d_we,
	output logic o_d_set_dirty,
	output logic o_d_data_sel,
	output logic o_addr_sel,
	output logic o_evict,
	output logic o_d_rdy
);

	mem_hierarchy_pkg::ctrl_state_t state;
	mem_hierarchy_pkg::ctrl_state_t next_state;

	logic d_req;

	assign d_req = i_d_re || i_d_we;

	always_ff @(posedge clk) begin
		if (i_reset) begin
			state <= mem_hierarchy_pkg::IDLE;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		next_state = state;
		o_u_re = 1'b0;
		o_u_we = 1'b0;
		o_i_we = 1'b0;
		o_d_we = 1'b0;
		o_d_set_dirty = 1'b0;
		o_d_data_sel = 1'b0;
		o_addr_sel = 1'b0;
		o_evict = 1'b0;
		o_d_rdy = 1'b0;

		unique case (state)
			mem_hierarchy_pkg::IDLE: begin
				// Instruction side always wins
				if (!i_i_hit) begin
					next_state = mem_hierarchy_pkg::I_FILL;
				end else if (d_req && !i_d_hit) begin
					if (i_d_dirty) begin
						next_state = mem_hierarchy_pkg::D_WB;
					end else begin
						next_state = mem_hierarchy_pkg::D_FILL;
					end
				end else if (i_d_we) begin
					// Write hit merges the store word into the line
					o_d_we = 1'b1;
					o_d_set_dirty = 1'b1;
					o_d_rdy = 1'b1;
				end else if (i_d_re) begin
					o_d_rdy = 1'b1;
				end
			end

			mem_hierarchy_pkg::I_FILL: begin
				o_u_re = 1'b1;
				if (i_u_rdy) begin
					o_i_we = 1'b1;
					next_state = mem_hierarchy_pkg::IDLE;
				end
			end

			mem_hierarchy_pkg::D_WB: begin
				// Victim goes out at {old tag, index}
				o_u_we = 1'b1;
				o_addr_sel = 1'b1;
				o_evict = 1'b1;
				if (i_u_rdy) begin
					next_state = mem_hierarchy_pkg::D_FILL;
				end
			end

			mem_hierarchy_pkg::D_FILL: begin
				o_u_re = 1'b1;
				o_addr_sel = 1'b1;
				o_d_data_sel = 1'b1;
				if (i_u_rdy) begin
					o_d_we = 1'b1;
					next_state = mem_hierarchy_pkg::IDLE;
				end
			end

			default: begin
				next_state = mem_hierarchy_pkg::IDLE;
			end
		endcase
	end

	a_one_mem_op: assert property (
		@(posedge clk) disable iff (i_reset)
		!(o_u_re && o_u_we)
	) else $error("cache_controller: memory read and write at once");

	a_d_rdy_idle: assert property (
		@(posedge clk) disable iff (i_reset)
		o_d_rdy |-> (state == mem_hierarchy_pkg::IDLE)
	) else $error("cache_controller: data ready outside IDLE");

endmodule

// ==== unified_mem.sv ====
`timescale 1ns/1ps

module unified_mem (
	input logic clk,
	input logic i_reset,
	input logic i_re,
	input logic i_we,
	input logic [mem_hierarchy_pkg::LINE_ADDR_W-1:0] i_addr,
	input mem_hierarchy_pkg::line_t i_wdata,
	output mem_hierarchy_pkg::line_t o_rd_data,
	output logic o_rdy
);

	mem_hierarchy_pkg::line_t mem_array [2 ** mem_hierarchy_pkg::LINE_ADDR_W];

	logic busy;
	logic [mem_hierarchy_pkg::MEM_CNT_W-1:0] count;
	logic start;
	logic done;

	// No restart in the ready cycle while the requester still holds its enable
	assign start = !busy && !o_rdy && (i_re || i_we);
	assign done = busy && (count == mem_hierarchy_pkg::MEM_CNT_LAST);

	// Every word starts out holding its own address
	initial begin
		for (int l = 0; l < 2 ** mem_hierarchy_pkg::LINE_ADDR_W; l++) begin
			for (int w = 0; w < mem_hierarchy_pkg::LINE_WORDS; w++) begin
				mem_array[l].words[w] = {l[mem_hierarchy_pkg::LINE_ADDR_W-1:0],
					w[mem_hierarchy_pkg::OFFSET_W-1:0]};
			end
		end
	end

	always_ff @(posedge clk) begin
		if (i_reset) begin
			busy <= 1'b0;
			count <= '0;
			o_rdy <= 1'b0;
		end else begin
			o_rdy <= done;
			if (start) begin
				busy <= 1'b1;
				count <= 1'b1;
			end else if (done) begin
				busy <= 1'b0;
			end else if (busy) begin
				count <= count + 1'b1;
			end
		end
	end

	always @(posedge clk) begin
		if (done) begin
			if (i_we) begin
				mem_array[i_addr].raw <= i_wdata.raw;
			end else begin
				o_rd_data.raw <= mem_array[i_addr].raw;
			end
		end
	end

	a_req_stable: assert property (
		@(posedge clk) disable iff (i_reset)
		busy |-> ($stable(i_re) && $stable(i_we) && $stable(i_addr))
	) else $error("unified_mem: request changed during access");

endmodule

// ==== dcache_datapath.sv ====
`timescale 1ns/1ps

module dcache_datapath (
	input logic [mem_hierarchy_pkg::ADDR_W-1:0] i_d_addr,
	input logic [mem_hierarchy_pkg::WORD_W-1:0] i_wrt_data,
	input mem_hierarchy_pkg::line_t i_cache_line,
	input mem_hierarchy_pkg::line_t i_mem_line,
	input logic [mem_hierarchy_pkg::TAG_W-1:0] i_victim_tag,
	input logic i_data_sel,
	input logic i_evict,
	output logic [mem_hierarchy_pkg::WORD_W-1:0] o_rd_word,
	output mem_hierarchy_pkg::line_t o_wr_line,
	output logic [mem_hierarchy_pkg::LINE_ADDR_W-1:0] o_mem_addr
);

	logic [mem_hierarchy_pkg::OFFSET_W-1:0] offset;
	logic [mem_hierarchy_pkg::INDEX_W-1:0] index;
	mem_hierarchy_pkg::line_t store_line;

	assign offset = i_d_addr[mem_hierarchy_pkg::OFFSET_W-1:0];
	assign index = i_d_addr[mem_hierarchy_pkg::OFFSET_W +: mem_hierarchy_pkg::INDEX_W];

	assign o_rd_word = i_cache_line.words[offset];

	// Store line is the cached line with one word replaced
	always_comb begin
		store_line = i_cache_line;
		store_line.words[offset] = i_wrt_data;
	end

	// Fill takes the memory line and a write hit takes the merged one
	assign o_wr_line = i_data_sel ? i_mem_line : store_line;

	// Victim lives at the same index under the tag still in the cache
	always_comb begin
		if (i_evict) begin
			o_mem_addr = {i_victim_tag, index};
		end else begin
			o_mem_addr = i_d_addr[mem_hierarchy_pkg::ADDR_W-1:mem_hierarchy_pkg::OFFSET_W];
		end
	end

endmodule

// ==== mem_hierarchy.sv ====
`timescale 1ns/1ps

module mem_hierarchy (
	input logic clk,
	input logic i_reset,
	input logic [mem_hierarchy_pkg::ADDR_W-1:0] i_i_addr,
	input logic [mem_hierarchy_pkg::ADDR_W-1:0] i_d_addr,
	input logic [mem_hierarchy_pkg::WORD_W-1:0] i_wrt_data,
	input logic i_d_re,
	input logic i_d_we,
	output logic [mem_hierarchy_pkg::WORD_W-1:0] o_instr,
	output logic o_i_rdy,
	output logic [mem_hierarchy_pkg::WORD_W-1:0] o_d_rd_data,
	output logic o_d_rdy
);

	mem_hierarchy_pkg::line_t ic_line;
	mem_hierarchy_pkg::line_t dc_line;
	mem_hierarchy_pkg::line_t dc_wr_line;
	mem_hierarchy_pkg::line_t mem_rd_line;

	logic [mem_hierarchy_pkg::TAG_W-1:0] dc_tag;
	logic [mem_hierarchy_pkg::LINE_ADDR_W-1:0] i_line_addr;
	logic [mem_hierarchy_pkg::LINE_ADDR_W-1:0] d_line_addr;
	logic [mem_hierarchy_pkg::LINE_ADDR_W-1:0] dp_mem_addr;
	logic [mem_hierarchy_pkg::LINE_ADDR_W-1:0] mem_addr;

	logic i_hit;
	logic d_hit;
	logic d_dirty;
	logic u_re;
	logic u_we;
	logic u_rdy;
	logic i_we;
	logic d_we;
	logic d_set_dirty;
	logic d_data_sel;
	logic addr_sel;
	logic evict;

	assign i_line_addr = i_i_addr[mem_hierarchy_pkg::ADDR_W-1:mem_hierarchy_pkg::OFFSET_W];
	assign d_line_addr = i_d_addr[mem_hierarchy_pkg::ADDR_W-1:mem_hierarchy_pkg::OFFSET_W];

	// Instruction cache is filled only from memory and never dirty
	cache ic_inst (
		.clk(clk),
		.i_reset(i_reset),
		.i_line_addr(i_line_addr),
		.i_wr_line(mem_rd_line),
		.i_we(i_we),
		.i_set_dirty(1'b0),
		.o_rd_line(ic_line),
		.o_tag(),
		.o_hit(i_hit),
		.o_dirty()
	);

	cache dc_inst (
		.clk(clk),
		.i_reset(i_reset),
		.i_line_addr(d_line_addr),
		.i_wr_line(dc_wr_line),
		.i_we(d_we),
		.i_set_dirty(d_set_dirty),
		.o_rd_line(dc_line),
		.o_tag(dc_tag),
		.o_hit(d_hit),
		.o_dirty(d_dirty)
	);

	cache_controller cc_inst (
		.clk(clk),
		.i_reset(i_reset),
		.i_i_hit(i_hit),
		.i_d_hit(d_hit),
		.i_d_dirty(d_dirty),
		.i_d_re(i_d_re),
		.i_d_we(i_d_we),
		.i_u_rdy(u_rdy),
		.o_u_re(u_re),
		.o_u_we(u_we),
		.o_i_we(i_we),
		.o_d_we(d_we),
		.o_d_set_dirty(d_set_dirty),
		.o_d_data_sel(d_data_sel),
		.o_addr_sel(addr_sel),
		.o_evict(evict),
		.o_d_rdy(o_d_rdy)
	);

	dcache_datapath dp_inst (
		.i_d_addr(i_d_addr),
		.i_wrt_data(i_wrt_data),
		.i_cache_line(dc_line),
		.i_mem_line(mem_rd_line),
		.i_victim_tag(dc_tag),
		.i_data_sel(d_data_sel),
		.i_evict(evict),
		.o_rd_word(o_d_rd_data),
		.o_wr_line(dc_wr_line),
		.o_mem_addr(dp_mem_addr)
	);

	// Memory follows whichever side the controller is serving
	assign mem_addr = addr_sel ? dp_mem_addr : i_line_addr;

	// Write data is always the data cache line and only write-backs use it
	unified_mem mem_inst (
		.clk(clk),
		.i_reset(i_reset),
		.i_re(u_re),
		.i_we(u_we),
		.i_addr(mem_addr),
		.i_wdata(dc_line),
		.o_rd_data(mem_rd_line),
		.o_rdy(u_rdy)
	);

	assign o_instr = ic_line.words[i_i_addr[mem_hierarchy_pkg::OFFSET_W-1:0]];
	assign o_i_rdy = i_hit;

endmodule

// ==== mem_hierarchy_tb.sv ====
`timescale 1ns/1ps

module mem_hierarchy_tb;

	localparam int TIMEOUT = 50;
	localparam logic [7:0] FETCH_TAG = 8'hf0;
	localparam logic [7:0] DATA_TAG = 8'h10;

	logic clk;
	logic i_reset;
	logic [mem_hierarchy_pkg::ADDR_W-1:0] i_i_addr;
	logic [mem_hierarchy_pkg::ADDR_W-1:0] i_d_addr;
	logic [mem_hierarchy_pkg::WORD_W-1:0] i_wrt_data;
	logic i_d_re;
	logic i_d_we;
	logic [mem_hierarchy_pkg::WORD_W-1:0] o_instr;
	logic o_i_rdy;
	logic [mem_hierarchy_pkg::WORD_W-1:0] o_d_rd_data;
	logic o_d_rdy;

	// Expected responses for the request currently on each port
	logic [mem_hierarchy_pkg::WORD_W-1:0] exp_instr;
	logic [mem_hierarchy_pkg::WORD_W-1:0] exp_rd;

	// Only words stored by the testbench live here
	logic [15:0] model_mem [logic [15:0]];

	mem_hierarchy mem_hierarchy_inst (
		.clk(clk),
		.i_reset(i_reset),
		.i_i_addr(i_i_addr),
		.i_d_addr(i_d_addr),
		.i_wrt_data(i_wrt_data),
		.i_d_re(i_d_re),
		.i_d_we(i_d_we),
		.o_instr(o_instr),
		.o_i_rdy(o_i_rdy),
		.o_d_rd_data(o_d_rd_data),
		.o_d_rdy(o_d_rdy)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic logic [15:0] model_read(input logic [15:0] addr);
		if (model_mem.exists(addr)) begin
			return model_mem[addr];
		end
		return addr;
	endfunction

	function automatic logic [15:0] make_addr(input logic [7:0] tag, input logic [5:0] idx,
			input logic [1:0] off);
		return {tag, idx, off};
	endfunction

	task automatic wait_instr(output int cycles);
		cycles = 0;
		@(negedge clk);
		while (!o_i_rdy) begin
			if (cycles == TIMEOUT) begin
				$display("Fetch at address %h was not answered within %0d cycles",
					i_i_addr, TIMEOUT);
				$display("Simulation FAILED");
				$fatal(1, "instruction port timed out");
			end
			cycles++;
			@(negedge clk);
		end
	endtask

	task automatic fetch(input logic [15:0] addr, output int cycles);
		@(posedge clk);
		#2;
		i_i_addr = addr;
		exp_instr = model_read(addr);
		wait_instr(cycles);
	endtask

	// One read or write held until o_d_rdy and dropped in the next cycle
	task automatic data_access(input logic is_write, input logic [15:0] addr,
			input logic [15:0] wdata, output int cycles);
		@(posedge clk);
		#2;
		i_d_addr = addr;
		i_wrt_data = wdata;
		exp_rd = model_read(addr);
		i_d_we = is_write;
		i_d_re = !is_write;
		cycles = 0;
		@(negedge clk);
		while (!o_d_rdy) begin
			if (cycles == TIMEOUT) begin
				$display("Data access at address %h was not answered within %0d cycles",
					addr, TIMEOUT);
				$display("Simulation FAILED");
				$fatal(1, "data port timed out");
			end
			cycles++;
			@(negedge clk);
		end
		@(posedge clk);
		#2;
		i_d_re = 1'b0;
		i_d_we = 1'b0;
		if (is_write) begin
			model_mem[addr] = wdata;
		end
	endtask

	task automatic check_latency(input string what, input int cycles, input bit want_hit);
		if (want_hit != (cycles == 0)) begin
			$display("%s was expected to %s but waited %0d cycles", what,
				want_hit ? "hit" : "miss", cycles);
			$display("Simulation FAILED");
			$fatal(1, "unexpected hit or miss");
		end
	endtask

	a_instr_value: assert property (
		@(posedge clk) disable iff (i_reset)
		o_i_rdy |-> (o_instr == exp_instr)
	) else begin
		$display("[ERROR] o_instr expected %h actual %h", $sampled(exp_instr), $sampled(o_instr));
		$display("Simulation FAILED");
		$fatal(1, "instruction mismatch");
	end

	a_rd_value: assert property (
		@(posedge clk) disable iff (i_reset)
		(o_d_rdy && i_d_re) |-> (o_d_rd_data == exp_rd)
	) else begin
		$display("[ERROR] o_d_rd_data expected %h actual %h", $sampled(exp_rd),
			$sampled(o_d_rd_data));
		$display("Simulation FAILED");
		$fatal(1, "read data mismatch");
	end

	initial begin : stimulus
		int cycles;
		int i_cycles;
		int d_cycles;
		int op;
		logic [15:0] addr_a;
		logic [15:0] addr_b;
		logic [15:0] value;

		void'($urandom(32'h0969_5a70));
		i_reset = 1'b1;
		i_i_addr = make_addr(FETCH_TAG, 6'd0, 2'd0);
		exp_instr = model_read(make_addr(FETCH_TAG, 6'd0, 2'd0));
		i_d_addr = '0;
		i_wrt_data = '0;
		i_d_re = 1'b0;
		i_d_we = 1'b0;
		exp_rd = '0;
		repeat (10) @(posedge clk);
		#2;
		i_reset = 1'b0;

		// Quiet ports after reset while the first fetch is still filling
		repeat (3) begin
			@(negedge clk);
			if (o_i_rdy || o_d_rdy) begin
				$display("[ERROR] o_i_rdy expected 0 actual %h, o_d_rdy expected 0 actual %h",
					o_i_rdy, o_d_rdy);
				$display("Simulation FAILED");
				$fatal(1, "ready high after reset");
			end
		end
		wait_instr(cycles);
		fetch(make_addr(FETCH_TAG, 6'd0, 2'd3), cycles);
		check_latency("Second fetch in line", cycles, 1'b1);

		// Unwritten word misses then hits
		addr_a = make_addr(DATA_TAG, 6'd2, 2'd1);
		data_access(1'b0, addr_a, 16'h0, cycles);
		check_latency("First data read", cycles, 1'b0);
		data_access(1'b0, addr_a, 16'h0, cycles);
		check_latency("Repeated data read", cycles, 1'b1);

		// Store then read back with neighbors
		addr_a = make_addr(DATA_TAG, 6'd3, 2'd1);
		data_access(1'b1, addr_a, 16'hbeef, cycles);
		data_access(1'b0, addr_a, 16'h0, cycles);
		data_access(1'b0, make_addr(DATA_TAG, 6'd3, 2'd0), 16'h0, cycles);
		data_access(1'b0, make_addr(DATA_TAG, 6'd3, 2'd2), 16'h0, cycles);

		// Dirty victim must reach memory before the conflicting fill
		addr_a = make_addr(DATA_TAG + 8'h10, 6'd5, 2'd2);
		addr_b = make_addr(DATA_TAG + 8'h11, 6'd5, 2'd2);
		data_access(1'b1, addr_a, 16'h5a5a, cycles);
		data_access(1'b0, addr_b, 16'h0, cycles);
		data_access(1'b0, addr_a, 16'h0, cycles);
		check_latency("Read after eviction", cycles, 1'b0);

		// Both sides miss in the same cycle with a dirty data victim
		data_access(1'b1, make_addr(DATA_TAG, 6'd9, 2'd0), 16'h1234, cycles);
		fork
			fetch(make_addr(FETCH_TAG + 8'h1, 6'd9, 2'd1), i_cycles);
			data_access(1'b0, make_addr(DATA_TAG + 8'h1, 6'd9, 2'd3), 16'h0, d_cycles);
		join
		check_latency("Concurrent fetch", i_cycles, 1'b0);
		check_latency("Concurrent data read", d_cycles, 1'b0);

		// Random mix over a few tags and indexes to force conflicts
		for (int n = 0; n < 200; n++) begin
			op = $urandom_range(2, 0);
			value = 16'($urandom);
			if (op == 0) begin
				addr_a = make_addr(FETCH_TAG + 8'($urandom_range(2, 0)),
					6'($urandom_range(3, 0)), 2'($urandom_range(3, 0)));
				fetch(addr_a, cycles);
			end else begin
				addr_a = make_addr(DATA_TAG + 8'($urandom_range(3, 0)),
					6'($urandom_range(3, 0)), 2'($urandom_range(3, 0)));
				data_access(op == 2, addr_a, value, cycles);
			end
		end

		repeat (2) @(posedge clk);
		$display("Simulation PASSED");
		$finish;
	end

endmodule

// ==== mem_hierarchy.f ====
mem_hierarchy_pkg.sv
cache.sv
cache_controller.sv
unified_mem.sv
dcache_datapath.sv
mem_hierarchy.sv
mem_hierarchy_tb.sv
